/* logic/mdq_pkg.sv */
package mdq_pkg;

    // ------------------------------------------------------------------
    // default sizes, overridden through the top level parameters
    // ------------------------------------------------------------------
    parameter int IQ_DEPTH  = 4;    // queue entries
    parameter int ROB_DEPTH = 16;   // tag = rob slot of the producer
    parameter int WORD_W    = 32;   // operand and immediate width
    parameter int PC_W      = 32;
    parameter int WB_PORTS  = 3;    // writeback broadcast ports

    // unit selector values in the opcode word
    parameter logic UNIT_MUL = 1'b0;
    parameter logic UNIT_DIV = 1'b1;

    // ------------------------------------------------------------------
    // opcode word
    // ------------------------------------------------------------------
    // the unit only sees raw, the queue only looks at the unit bit
    // mul: 00 mul, 01 mulh, 10 mulhsu, 11 mulhu
    // div: 00 div, 01 divu, 10 rem, 11 remu
    typedef union packed {
        logic [2:0] raw;
        struct packed {
            logic       unit;   // 0 = mul, 1 = div
            logic [1:0] func;
        } fields;
    } op_t;

endpackage

/* logic/oldest_ready_select.sv */
`timescale 1ns/1ps

module oldest_ready_select #(
    parameter int IQ_DEPTH = 4,
    localparam int IDX_W   = $clog2(IQ_DEPTH)
) (
    input  logic [IQ_DEPTH-1:0]            entry_valid,
    input  logic [IQ_DEPTH-1:0]            entry_src1_wait,
    input  logic [IQ_DEPTH-1:0]            entry_src2_wait,
    input  mdq_pkg::op_t [IQ_DEPTH-1:0]    entry_op,
    input  logic                           mul_ready,
    input  logic                           div_ready,
    output logic                           issue_fire,
    output logic [IDX_W-1:0]               issue_idx
);

    logic [IQ_DEPTH-1:0] ready;
    logic                found;
    mdq_pkg::op_t        sel_op;
    logic                unit_ready;

    assign ready = entry_valid & ~entry_src1_wait & ~entry_src2_wait;

    // ------------------------------------------------------------------
    // priority pick, slot 0 is the oldest
    // ------------------------------------------------------------------
    always_comb begin
        found     = 1'b0;
        issue_idx = '0;
        for (int j = 0; j < IQ_DEPTH; j++) begin
            if (!found && ready[j]) begin
                found     = 1'b1;
                issue_idx = IDX_W'(j);
            end
        end
    end

    // the pick waits for its unit, younger ops never go around it
    assign sel_op     = entry_op[issue_idx];
    assign unit_ready = (sel_op.fields.unit == mdq_pkg::UNIT_MUL) ? mul_ready : div_ready;
    assign issue_fire = found && unit_ready;

endmodule

/* logic/operand_wakeup.sv */
`timescale 1ns/1ps

module operand_wakeup #(
    parameter int IQ_DEPTH  = 4,
    parameter int ROB_DEPTH = 16,
    parameter int WB_PORTS  = 3,
    parameter int WORD_W    = 32,
    localparam int TAG_W    = $clog2(ROB_DEPTH),
    localparam int IDX_W    = $clog2(IQ_DEPTH)
) (
    input  logic [WB_PORTS-1:0]                wb_valid,
    input  logic [WB_PORTS-1:0][TAG_W-1:0]     wb_tag,
    input  logic [WB_PORTS-1:0][WORD_W-1:0]    wb_data,

    input  logic [IQ_DEPTH-1:0]                entry_valid,
    input  logic [IQ_DEPTH-1:0]                entry_src1_wait,
    input  logic [IQ_DEPTH-1:0]                entry_src2_wait,
    input  logic [IQ_DEPTH-1:0][TAG_W-1:0]     entry_src1_tag,
    input  logic [IQ_DEPTH-1:0][TAG_W-1:0]     entry_src2_tag,
    input  logic [IQ_DEPTH:0]                  fill_onehot,
    input  logic                               issue_fire,
    input  logic [IDX_W-1:0]                   issue_idx,

    input  logic                               dispatch_en,
    input  logic                               queue_full,
    input  logic                               src1_wait,
    input  logic [TAG_W-1:0]                   src1_tag,
    input  logic                               src2_wait,
    input  logic [TAG_W-1:0]                   src2_tag,

    output logic [IQ_DEPTH-1:0]                wake_src1,
    output logic [IQ_DEPTH-1:0]                wake_src2,
    output logic [IQ_DEPTH-1:0][WORD_W-1:0]    wake_data1,
    output logic [IQ_DEPTH-1:0][WORD_W-1:0]    wake_data2,
    output logic                               in_wake1,
    output logic                               in_wake2,
    output logic [WORD_W-1:0]                  in_data1,
    output logic [WORD_W-1:0]                  in_data2
);

    // {hit, data} for one tag, lowest port wins
    function automatic logic [WORD_W:0] match_wb(
        input logic [TAG_W-1:0]                tag,
        input logic [WB_PORTS-1:0]             valid,
        input logic [WB_PORTS-1:0][TAG_W-1:0]  tags,
        input logic [WB_PORTS-1:0][WORD_W-1:0] data
    );
        logic [WORD_W:0] hit;
        hit = '0;
        for (int p = WB_PORTS - 1; p >= 0; p--) begin
            if (valid[p] && (tags[p] == tag)) begin
                hit = {1'b1, data[p]};
            end
        end
        return hit;
    endfunction

    logic live;
    logic accept;
    logic [WORD_W:0] in_hit1;
    logic [WORD_W:0] in_hit2;

    assign live   = !fill_onehot[0];    // nothing stored to wake
    assign accept = dispatch_en && !queue_full;

    // ------------------------------------------------------------------
    // stored sources, seen at the slot they occupy after the collapse
    // ------------------------------------------------------------------
    for (genvar j = 0; j < IQ_DEPTH; j++) begin : g_entry
        localparam int UP = (j == IQ_DEPTH-1) ? j : j + 1;
        logic            from_up;
        logic            src_ok;
        logic [WORD_W:0] hit1;
        logic [WORD_W:0] hit2;

        assign from_up = issue_fire && (issue_idx <= IDX_W'(j));
        assign src_ok  = live && (from_up ? (UP != j) && entry_valid[UP] : entry_valid[j]);
        assign hit1 = match_wb(from_up ? entry_src1_tag[UP] : entry_src1_tag[j],
                               wb_valid, wb_tag, wb_data);
        assign hit2 = match_wb(from_up ? entry_src2_tag[UP] : entry_src2_tag[j],
                               wb_valid, wb_tag, wb_data);

        assign wake_src1[j] = src_ok && hit1[WORD_W]
                              && (from_up ? entry_src1_wait[UP] : entry_src1_wait[j]);
        assign wake_src2[j] = src_ok && hit2[WORD_W]
                              && (from_up ? entry_src2_wait[UP] : entry_src2_wait[j]);
        assign wake_data1[j] = hit1[WORD_W-1:0];
        assign wake_data2[j] = hit2[WORD_W-1:0];
    end

    // incoming dispatch, broadcast in the same cycle
    assign in_hit1  = match_wb(src1_tag, wb_valid, wb_tag, wb_data);
    assign in_hit2  = match_wb(src2_tag, wb_valid, wb_tag, wb_data);
    assign in_wake1 = accept && src1_wait && in_hit1[WORD_W];
    assign in_wake2 = accept && src2_wait && in_hit2[WORD_W];
    assign in_data1 = in_hit1[WORD_W-1:0];
    assign in_data2 = in_hit2[WORD_W-1:0];

endmodule

/* logic/collapse_queue.sv */
`timescale 1ns/1ps

module collapse_queue #(
    parameter int IQ_DEPTH  = 4,
    parameter int ROB_DEPTH = 16,
    parameter int WORD_W    = 32,
    localparam int TAG_W    = $clog2(ROB_DEPTH),
    localparam int IDX_W    = $clog2(IQ_DEPTH)
) (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic                               dispatch_en,
    input  mdq_pkg::op_t                       dispatch_op,
    input  logic [mdq_pkg::PC_W-1:0]           dispatch_pc,
    input  logic [WORD_W-1:0]                  dispatch_imm,
    input  logic [TAG_W-1:0]                   dispatch_dst,
    input  logic                               src1_wait,
    input  logic [TAG_W-1:0]                   src1_tag,
    input  logic [WORD_W-1:0]                  src1_value,
    input  logic                               src2_wait,
    input  logic [TAG_W-1:0]                   src2_tag,
    input  logic [WORD_W-1:0]                  src2_value,

    input  logic                               commit_br_taken,
    input  logic                               commit_exp,
    input  logic                               issue_fire,
    input  logic [IDX_W-1:0]                   issue_idx,

    input  logic [IQ_DEPTH-1:0]                wake_src1,
    input  logic [IQ_DEPTH-1:0]                wake_src2,
    input  logic [IQ_DEPTH-1:0][WORD_W-1:0]    wake_data1,
    input  logic [IQ_DEPTH-1:0][WORD_W-1:0]    wake_data2,
    input  logic                               in_wake1,
    input  logic                               in_wake2,
    input  logic [WORD_W-1:0]                  in_data1,
    input  logic [WORD_W-1:0]                  in_data2,

    output logic [IQ_DEPTH-1:0]                entry_valid,
    output logic [IQ_DEPTH-1:0]                entry_src1_wait,
    output logic [IQ_DEPTH-1:0]                entry_src2_wait,
    output logic [IQ_DEPTH-1:0][TAG_W-1:0]     entry_src1_tag,
    output logic [IQ_DEPTH-1:0][TAG_W-1:0]     entry_src2_tag,
    output mdq_pkg::op_t [IQ_DEPTH-1:0]        entry_op,
    output logic [IQ_DEPTH:0]                  fill_onehot,
    output logic                               queue_full,

    output mdq_pkg::op_t                       issue_op,
    output logic [mdq_pkg::PC_W-1:0]           issue_pc,
    output logic [WORD_W-1:0]                  issue_imm,
    output logic [WORD_W-1:0]                  issue_src1,
    output logic [WORD_W-1:0]                  issue_src2,
    output logic [TAG_W-1:0]                   issue_dst
);

    // payload per entry
    logic [IQ_DEPTH-1:0][mdq_pkg::PC_W-1:0]   pc_q;
    logic [IQ_DEPTH-1:0][WORD_W-1:0]          imm_q;
    logic [IQ_DEPTH-1:0][WORD_W-1:0]          val1_q;
    logic [IQ_DEPTH-1:0][WORD_W-1:0]          val2_q;
    logic [IQ_DEPTH-1:0][TAG_W-1:0]           dst_q;

    logic                  flush;
    logic                  accept;
    logic [IQ_DEPTH-1:0]   shift;      // slot takes its upper neighbor
    logic [IQ_DEPTH-1:0]   land;       // slot the incoming op goes to

    assign flush      = commit_br_taken || commit_exp;
    assign queue_full = fill_onehot[IQ_DEPTH];
    assign accept     = dispatch_en && !queue_full;

    // one slot lower when the queue collapses in the same cycle
    assign land = issue_fire ? fill_onehot[IQ_DEPTH:1] : fill_onehot[IQ_DEPTH-1:0];

    for (genvar j = 0; j < IQ_DEPTH; j++) begin : g_slot
        assign entry_valid[j] = ~|fill_onehot[j:0];     // below the pointer
        assign shift[j]       = issue_fire && (issue_idx <= IDX_W'(j));
    end

    // ------------------------------------------------------------------
    // fill pointer, bit 0 empty, top bit full
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_onehot <= (IQ_DEPTH+1)'(1);
        end else if (flush) begin
            fill_onehot <= (IQ_DEPTH+1)'(1);
        end else if (accept && !issue_fire) begin
            fill_onehot <= {fill_onehot[IQ_DEPTH-1:0], 1'b0};
        end else if (issue_fire && !accept) begin
            fill_onehot <= {1'b0, fill_onehot[IQ_DEPTH:1]};
        end
    end

    // ------------------------------------------------------------------
    // write, collapse and operand capture
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int j = 0; j < IQ_DEPTH; j++) begin
            int up;
            up = (j == IQ_DEPTH-1) ? j : j + 1;     // top slot has no neighbor
            if (accept && land[j]) begin
                entry_op[j]        <= dispatch_op;
                pc_q[j]            <= dispatch_pc;
                imm_q[j]           <= dispatch_imm;
                dst_q[j]           <= dispatch_dst;
                entry_src1_tag[j]  <= src1_tag;
                entry_src2_tag[j]  <= src2_tag;
                entry_src1_wait[j] <= src1_wait && !in_wake1;   // same-cycle broadcast
                entry_src2_wait[j] <= src2_wait && !in_wake2;
                val1_q[j]          <= in_wake1 ? in_data1 : src1_value;
                val2_q[j]          <= in_wake2 ? in_data2 : src2_value;
            end else begin
                if (shift[j]) begin
                    entry_op[j]        <= entry_op[up];
                    pc_q[j]            <= pc_q[up];
                    imm_q[j]           <= imm_q[up];
                    dst_q[j]           <= dst_q[up];
                    entry_src1_tag[j]  <= entry_src1_tag[up];
                    entry_src2_tag[j]  <= entry_src2_tag[up];
                    entry_src1_wait[j] <= entry_src1_wait[up];
                    entry_src2_wait[j] <= entry_src2_wait[up];
                    val1_q[j]          <= val1_q[up];
                    val2_q[j]          <= val2_q[up];
                end
                // wake flags already point at the post-shift slot
                if (wake_src1[j]) begin
                    entry_src1_wait[j] <= 1'b0;
                    val1_q[j]          <= wake_data1[j];
                end
                if (wake_src2[j]) begin
                    entry_src2_wait[j] <= 1'b0;
                    val2_q[j]          <= wake_data2[j];
                end
            end
        end
    end

    // issued payload
    assign issue_op   = entry_op[issue_idx];
    assign issue_pc   = pc_q[issue_idx];
    assign issue_imm  = imm_q[issue_idx];
    assign issue_src1 = val1_q[issue_idx];
    assign issue_src2 = val2_q[issue_idx];
    assign issue_dst  = dst_q[issue_idx];

endmodule

/* logic/md_issue_queue.sv */
`timescale 1ns/1ps

module md_issue_queue #(
    parameter int IQ_DEPTH  = mdq_pkg::IQ_DEPTH,
    parameter int ROB_DEPTH = mdq_pkg::ROB_DEPTH,
    parameter int WB_PORTS  = mdq_pkg::WB_PORTS,
    parameter int WORD_W    = mdq_pkg::WORD_W,
    localparam int TAG_W    = $clog2(ROB_DEPTH)
) (
    input  logic                               clk,
    input  logic                               rst_n,

    // dispatch
    input  logic                               dispatch_en,
    input  mdq_pkg::op_t                       dispatch_op,
    input  logic [mdq_pkg::PC_W-1:0]           dispatch_pc,
    input  logic [WORD_W-1:0]                  dispatch_imm,
    input  logic [TAG_W-1:0]                   dispatch_dst,    // own rob slot
    input  logic                               src1_wait,
    input  logic [TAG_W-1:0]                   src1_tag,
    input  logic [WORD_W-1:0]                  src1_value,
    input  logic                               src2_wait,
    input  logic [TAG_W-1:0]                   src2_tag,
    input  logic [WORD_W-1:0]                  src2_value,

    // writeback broadcast
    input  logic [WB_PORTS-1:0]                wb_valid,
    input  logic [WB_PORTS-1:0][TAG_W-1:0]     wb_tag,
    input  logic [WB_PORTS-1:0][WORD_W-1:0]    wb_data,

    input  logic                               commit_br_taken,
    input  logic                               commit_exp,
    input  logic                               mul_ready,
    input  logic                               div_ready,

    // to the mul/div units
    output logic                               issue_en,
    output mdq_pkg::op_t                       issue_op,
    output logic [mdq_pkg::PC_W-1:0]           issue_pc,
    output logic [WORD_W-1:0]                  issue_imm,
    output logic [WORD_W-1:0]                  issue_src1,
    output logic [WORD_W-1:0]                  issue_src2,
    output logic [TAG_W-1:0]                   issue_dst,
    output logic                               queue_full
);

    localparam int IDX_W = $clog2(IQ_DEPTH);

    // entry state seen by wakeup and select
    logic [IQ_DEPTH-1:0]                entry_valid;
    logic [IQ_DEPTH-1:0]                entry_src1_wait;
    logic [IQ_DEPTH-1:0]                entry_src2_wait;
    logic [IQ_DEPTH-1:0][TAG_W-1:0]     entry_src1_tag;
    logic [IQ_DEPTH-1:0][TAG_W-1:0]     entry_src2_tag;
    mdq_pkg::op_t [IQ_DEPTH-1:0]        entry_op;
    logic [IQ_DEPTH:0]                  fill_onehot;

    // wakeup results, per post-shift slot
    logic [IQ_DEPTH-1:0]                wake_src1;
    logic [IQ_DEPTH-1:0]                wake_src2;
    logic [IQ_DEPTH-1:0][WORD_W-1:0]    wake_data1;
    logic [IQ_DEPTH-1:0][WORD_W-1:0]    wake_data2;
    logic                               in_wake1;
    logic                               in_wake2;
    logic [WORD_W-1:0]                  in_data1;
    logic [WORD_W-1:0]                  in_data2;

    logic [IDX_W-1:0]                   issue_idx;

    collapse_queue #(
        .IQ_DEPTH  (IQ_DEPTH),
        .ROB_DEPTH (ROB_DEPTH),
        .WORD_W    (WORD_W)
    ) u_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .dispatch_en     (dispatch_en),
        .dispatch_op     (dispatch_op),
        .dispatch_pc     (dispatch_pc),
        .dispatch_imm    (dispatch_imm),
        .dispatch_dst    (dispatch_dst),
        .src1_wait       (src1_wait),
        .src1_tag        (src1_tag),
        .src1_value      (src1_value),
        .src2_wait       (src2_wait),
        .src2_tag        (src2_tag),
        .src2_value      (src2_value),
        .commit_br_taken (commit_br_taken),
        .commit_exp      (commit_exp),
        .issue_fire      (issue_en),
        .issue_idx       (issue_idx),
        .wake_src1       (wake_src1),
        .wake_src2       (wake_src2),
        .wake_data1      (wake_data1),
        .wake_data2      (wake_data2),
        .in_wake1        (in_wake1),
        .in_wake2        (in_wake2),
        .in_data1        (in_data1),
        .in_data2        (in_data2),
        .entry_valid     (entry_valid),
        .entry_src1_wait (entry_src1_wait),
        .entry_src2_wait (entry_src2_wait),
        .entry_src1_tag  (entry_src1_tag),
        .entry_src2_tag  (entry_src2_tag),
        .entry_op        (entry_op),
        .fill_onehot     (fill_onehot),
        .queue_full      (queue_full),
        .issue_op        (issue_op),
        .issue_pc        (issue_pc),
        .issue_imm       (issue_imm),
        .issue_src1      (issue_src1),
        .issue_src2      (issue_src2),
        .issue_dst       (issue_dst)
    );

    operand_wakeup #(
        .IQ_DEPTH  (IQ_DEPTH),
        .ROB_DEPTH (ROB_DEPTH),
        .WB_PORTS  (WB_PORTS),
        .WORD_W    (WORD_W)
    ) u_wakeup (
        .wb_valid        (wb_valid),
        .wb_tag          (wb_tag),
        .wb_data         (wb_data),
        .entry_valid     (entry_valid),
        .entry_src1_wait (entry_src1_wait),
        .entry_src2_wait (entry_src2_wait),
        .entry_src1_tag  (entry_src1_tag),
        .entry_src2_tag  (entry_src2_tag),
        .fill_onehot     (fill_onehot),
        .issue_fire      (issue_en),
        .issue_idx       (issue_idx),
        .dispatch_en     (dispatch_en),
        .queue_full      (queue_full),
        .src1_wait       (src1_wait),
        .src1_tag        (src1_tag),
        .src2_wait       (src2_wait),
        .src2_tag        (src2_tag),
        .wake_src1       (wake_src1),
        .wake_src2       (wake_src2),
        .wake_data1      (wake_data1),
        .wake_data2      (wake_data2),
        .in_wake1        (in_wake1),
        .in_wake2        (in_wake2),
        .in_data1        (in_data1),
        .in_data2        (in_data2)
    );

    oldest_ready_select #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_select (
        .entry_valid     (entry_valid),
        .entry_src1_wait (entry_src1_wait),
        .entry_src2_wait (entry_src2_wait),
        .entry_op        (entry_op),
        .mul_ready       (mul_ready),
        .div_ready       (div_ready),
        .issue_fire      (issue_en),
        .issue_idx       (issue_idx)
    );

endmodule

/* tb/md_issue_queue_tb.sv */
`timescale 1ns/1ps

module md_issue_queue_tb;

    localparam int IQ_DEPTH  = mdq_pkg::IQ_DEPTH;
    localparam int ROB_DEPTH = mdq_pkg::ROB_DEPTH;
    localparam int WB_PORTS  = mdq_pkg::WB_PORTS;
    localparam int WORD_W    = mdq_pkg::WORD_W;
    localparam int PC_W      = mdq_pkg::PC_W;
    localparam int TAG_W     = $clog2(ROB_DEPTH);
    localparam int PERIOD          = 100;
    localparam int DIRECTED_CYCLES = 200;   // upper bound of the directed part
    localparam int RAND_CYCLES     = 400;

    logic                             clk;
    logic                             rst_n;
    logic                             dispatch_en;
    mdq_pkg::op_t                     dispatch_op;
    logic [PC_W-1:0]                  dispatch_pc;
    logic [WORD_W-1:0]                dispatch_imm;
    logic [TAG_W-1:0]                 dispatch_dst;
    logic                             src1_wait;
    logic [TAG_W-1:0]                 src1_tag;
    logic [WORD_W-1:0]                src1_value;
    logic                             src2_wait;
    logic [TAG_W-1:0]                 src2_tag;
    logic [WORD_W-1:0]                src2_value;
    logic [WB_PORTS-1:0]              wb_valid;
    logic [WB_PORTS-1:0][TAG_W-1:0]   wb_tag;
    logic [WB_PORTS-1:0][WORD_W-1:0]  wb_data;
    logic                             commit_br_taken;
    logic                             commit_exp;
    logic                             mul_ready;
    logic                             div_ready;
    logic                             issue_en;
    mdq_pkg::op_t                     issue_op;
    logic [PC_W-1:0]                  issue_pc;
    logic [WORD_W-1:0]                issue_imm;
    logic [WORD_W-1:0]                issue_src1;
    logic [WORD_W-1:0]                issue_src2;
    logic [TAG_W-1:0]                 issue_dst;
    logic                             queue_full;

    integer seed = 66382;

    // reference queue, slot 0 oldest
    logic [2:0]        m_op   [IQ_DEPTH];
    logic [PC_W-1:0]   m_pc   [IQ_DEPTH];
    logic [WORD_W-1:0] m_imm  [IQ_DEPTH];
    logic [TAG_W-1:0]  m_dst  [IQ_DEPTH];
    logic              m_w1   [IQ_DEPTH];
    logic              m_w2   [IQ_DEPTH];
    logic [TAG_W-1:0]  m_t1   [IQ_DEPTH];
    logic [TAG_W-1:0]  m_t2   [IQ_DEPTH];
    logic [WORD_W-1:0] m_v1   [IQ_DEPTH];
    logic [WORD_W-1:0] m_v2   [IQ_DEPTH];
    int                m_count = 0;

    md_issue_queue UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic int oldest_ready();
        for (int j = 0; j < m_count; j++) begin
            if (!m_w1[j] && !m_w2[j]) return j;
        end
        return -1;
    endfunction

    // {hit, data}, first matching port from index 0 up
    function automatic logic [WORD_W:0] broadcast_hit(input logic [TAG_W-1:0] tag);
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_valid[p] && wb_tag[p] == tag) return {1'b1, wb_data[p]};
        end
        return '0;
    endfunction

    task automatic move_entry(input int d, input int s);
        m_op[d]  = m_op[s];
        m_pc[d]  = m_pc[s];
        m_imm[d] = m_imm[s];
        m_dst[d] = m_dst[s];
        m_w1[d]  = m_w1[s];
        m_w2[d]  = m_w2[s];
        m_t1[d]  = m_t1[s];
        m_t2[d]  = m_t2[s];
        m_v1[d]  = m_v1[s];
        m_v2[d]  = m_v2[s];
    endtask

    // one clock edge of the reference queue, from the inputs held before it
    task automatic update_model();
        int              idx;
        logic            fire;
        logic            accept;
        logic [WORD_W:0] hit;
        if (commit_br_taken || commit_exp) begin
            m_count = 0;
            return;
        end
        idx    = oldest_ready();
        fire   = (idx >= 0) && (m_op[idx][2] ? div_ready : mul_ready);
        accept = dispatch_en && (m_count < IQ_DEPTH);
        for (int j = 0; j < m_count; j++) begin
            hit = broadcast_hit(m_t1[j]);
            if (m_w1[j] && hit[WORD_W]) begin
                m_w1[j] = 1'b0;
                m_v1[j] = hit[WORD_W-1:0];
            end
            hit = broadcast_hit(m_t2[j]);
            if (m_w2[j] && hit[WORD_W]) begin
                m_w2[j] = 1'b0;
                m_v2[j] = hit[WORD_W-1:0];
            end
        end
        if (fire) begin
            for (int j = idx; j < m_count - 1; j++) move_entry(j, j + 1);
            m_count--;
        end
        if (accept) begin
            m_op[m_count]  = dispatch_op.raw;
            m_pc[m_count]  = dispatch_pc;
            m_imm[m_count] = dispatch_imm;
            m_dst[m_count] = dispatch_dst;
            m_t1[m_count]  = src1_tag;
            m_t2[m_count]  = src2_tag;
            hit = broadcast_hit(src1_tag);
            m_w1[m_count]  = src1_wait && !hit[WORD_W];
            m_v1[m_count]  = (src1_wait && hit[WORD_W]) ? hit[WORD_W-1:0] : src1_value;
            hit = broadcast_hit(src2_tag);
            m_w2[m_count]  = src2_wait && !hit[WORD_W];
            m_v2[m_count]  = (src2_wait && hit[WORD_W]) ? hit[WORD_W-1:0] : src2_value;
            m_count++;
        end
    endtask

    // ------------------------------------------------------------------
    // checking, at the falling edge where outputs are settled
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_outputs();
        int   idx;
        logic exp_en;
        idx    = oldest_ready();
        exp_en = (idx >= 0) && (m_op[idx][2] ? div_ready : mul_ready);
        check_value("issue_en", 64'(issue_en), 64'(exp_en));
        check_value("queue_full", 64'(queue_full), 64'(m_count == IQ_DEPTH));
        if (exp_en) begin
            check_value("issue_op", 64'(issue_op.raw), 64'(m_op[idx]));
            check_value("issue_pc", 64'(issue_pc), 64'(m_pc[idx]));
            check_value("issue_imm", 64'(issue_imm), 64'(m_imm[idx]));
            check_value("issue_src1", 64'(issue_src1), 64'(m_v1[idx]));
            check_value("issue_src2", 64'(issue_src2), 64'(m_v2[idx]));
            check_value("issue_dst", 64'(issue_dst), 64'(m_dst[idx]));
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) check_outputs();
    end

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    task automatic clear_strobes();
        dispatch_en     = 1'b0;
        wb_valid        = '0;
        commit_br_taken = 1'b0;
        commit_exp      = 1'b0;
    endtask

    task automatic step();
        @(posedge clk);
        update_model();
        #1;
        clear_strobes();
    endtask

    task automatic put_dispatch(input logic [2:0] op, input logic w1, input logic [TAG_W-1:0] t1,
                                input logic w2, input logic [TAG_W-1:0] t2);
        dispatch_en     = 1'b1;
        dispatch_op.raw = op;
        dispatch_pc     = $random(seed);
        dispatch_imm    = $random(seed);
        dispatch_dst    = TAG_W'($random(seed));
        src1_wait       = w1;
        src1_tag        = t1;
        src1_value      = $random(seed);
        src2_wait       = w2;
        src2_tag        = t2;
        src2_value      = $random(seed);
    endtask

    task automatic put_wb(input int port, input logic [TAG_W-1:0] tag,
                          input logic [WORD_W-1:0] data);
        wb_valid[port] = 1'b1;
        wb_tag[port]   = tag;
        wb_data[port]  = data;
    endtask

    // idle cycles with both units ready until the model is empty
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        mul_ready = 1'b1;
        div_ready = 1'b1;
        while (m_count > 0) begin
            if (n >= limit) begin
                $display("queue did not drain within %0d cycles", limit);
                $display("Some tests failed");
                $fatal(1);
            end
            step();
            n++;
        end
    endtask

    // watchdog
    initial begin
        #((DIRECTED_CYCLES + RAND_CYCLES + 10) * PERIOD);
        $display("simulation timed out");
        $display("Some tests failed");
        $fatal(1);
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n        = 1'b0;
        dispatch_op  = '0;
        dispatch_pc  = '0;
        dispatch_imm = '0;
        dispatch_dst = '0;
        src1_wait    = 1'b0;
        src1_tag     = '0;
        src1_value   = '0;
        src2_wait    = 1'b0;
        src2_tag     = '0;
        src2_value   = '0;
        wb_tag       = '0;
        wb_data      = '0;
        mul_ready    = 1'b1;
        div_ready    = 1'b1;
        clear_strobes();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) step();                  // empty queue stays quiet

        // ready operands, then div before mul with only the divider free
        put_dispatch(3'b001, 1'b0, 4'd0, 1'b0, 4'd0);
        step();
        wait_drain(5);
        mul_ready = 1'b0;
        put_dispatch(3'b110, 1'b0, 4'd0, 1'b0, 4'd0);
        step();
        put_dispatch(3'b010, 1'b0, 4'd0, 1'b0, 4'd0);
        step();
        repeat (3) step();
        wait_drain(5);

        // wakeup, two ports on one tag, then same-cycle broadcast
        put_dispatch(3'b011, 1'b1, 4'd5, 1'b0, 4'd0);
        step();
        repeat (3) step();
        put_wb(2, 4'd5, 32'hcafe_0002);
        put_wb(1, 4'd5, 32'hcafe_0001);
        step();
        wait_drain(5);
        put_dispatch(3'b100, 1'b1, 4'd7, 1'b1, 4'd9);
        put_wb(0, 4'd7, 32'h1234_5678);
        step();
        repeat (2) step();
        put_wb(2, 4'd9, 32'h0bad_f00d);
        step();
        wait_drain(5);

        // ordering and head blocking
        mul_ready = 1'b0;
        div_ready = 1'b0;
        put_dispatch(3'b000, 1'b0, 4'd0, 1'b0, 4'd0);
        step();
        put_dispatch(3'b101, 1'b0, 4'd0, 1'b0, 4'd0);
        step();
        put_dispatch(3'b111, 1'b1, 4'd3, 1'b0, 4'd0);
        step();
        div_ready = 1'b1;                   // oldest ready is a mul
        repeat (3) step();
        put_wb(0, 4'd3, 32'h0000_3333);
        wait_drain(10);

        // capacity, then flush
        mul_ready = 1'b0;
        div_ready = 1'b0;
        for (int k = 0; k <= IQ_DEPTH; k++) begin
            put_dispatch(3'($random(seed)), 1'b1, TAG_W'(k + 2), 1'b0, 4'd0);
            step();
        end
        mul_ready = 1'b1;
        div_ready = 1'b1;
        commit_exp = 1'b1;
        step();
        for (int k = 0; k <= IQ_DEPTH; k++) begin
            put_wb(0, TAG_W'(k + 2), 32'hdead_0000);
            step();
        end
        put_dispatch(3'b010, 1'b0, 4'd0, 1'b0, 4'd0);
        commit_br_taken = 1'b1;             // flush wins over dispatch
        step();
        step();

        // random traffic
        for (int c = 0; c < RAND_CYCLES; c++) begin
            mul_ready = 1'($random(seed));
            div_ready = 1'($random(seed));
            if ($random(seed) & 1) begin
                put_dispatch(3'($random(seed)), 1'($random(seed)), TAG_W'($random(seed)),
                             1'($random(seed)), TAG_W'($random(seed)));
            end
            for (int p = 0; p < WB_PORTS; p++) begin
                if (($random(seed) & 3) == 0) begin
                    put_wb(p, TAG_W'($random(seed)), $random(seed));
                end
            end
            if (($random(seed) & 31) == 0) commit_exp = 1'b1;
            step();
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* md_issue_queue.f */
logic/mdq_pkg.sv
logic/oldest_ready_select.sv
logic/operand_wakeup.sv
logic/collapse_queue.sv
logic/md_issue_queue.sv
tb/md_issue_queue_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the md_issue_queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f md_issue_queue.f \
    --top-module md_issue_queue_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vmd_issue_queue_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
fi
exit 1
